// ==== Bender.yml ====
package:
  name: midi_synth

sources:
  - include_dirs:
      - logic
    files:
      - logic/synth_pkg.sv
      - logic/midi_msg_parser.sv
      - logic/pitch_lookup.sv
      - logic/sample_rate_gen.sv
      - logic/pulse_voice.sv
      - logic/midi_synth_top.sv
  - target: simulation
    include_dirs:
      - logic
      - sim
    files:
      - sim/tb_midi_synth.sv

// ==== filelist.f ====
+incdir+logic
+incdir+sim
logic/synth_pkg.sv
logic/midi_msg_parser.sv
logic/pitch_lookup.sv
logic/sample_rate_gen.sv
logic/pulse_voice.sv
logic/midi_synth_top.sv
sim/tb_midi_synth.sv

// ==== logic/midi_msg_parser.sv ====
// MIDI note message parser

`include "synth_settings.svh"

module midi_msg_parser (
    input  logic                  reset,
    input  logic                  clk,
    input  logic [7:0]            midi_byte,
    input  logic                  midi_byte_valid,
    input  logic [3:0]            channel,
    output logic                  msg_valid,
    output synth_pkg::midi_msg_t  msg
);

    // Running status, none when no note status is active
    synth_pkg::msg_kind_e     run_kind;
    logic [3:0]               run_chan;
    logic                     have_data0;
    logic [`SYNTH_NOTE_W-1:0] data0;

    logic status_byte;
    logic data_byte;
    logic complete;

    assign status_byte = midi_byte_valid && midi_byte[7];
    assign data_byte   = midi_byte_valid && !midi_byte[7];
    assign complete    = data_byte && run_kind != synth_pkg::none && have_data0;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            run_kind   <= synth_pkg::none;
            run_chan   <= 4'd0;
            have_data0 <= 1'b0;
            msg_valid  <= 1'b0;
        end else begin
            msg_valid <= complete && run_chan == channel;
            if (status_byte) begin
                have_data0 <= 1'b0;
                run_chan   <= midi_byte[3:0];
                case (midi_byte[7:4])
                    4'h8:    run_kind <= synth_pkg::note_off;
                    4'h9:    run_kind <= synth_pkg::note_on;
                    default: run_kind <= synth_pkg::none;
                endcase
            end else if (data_byte && run_kind != synth_pkg::none) begin
                // Pairs of data bytes keep forming messages
                have_data0 <= !have_data0;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (data_byte && !have_data0) begin
            data0 <= midi_byte[6:0];
        end
        if (complete) begin
            msg.note     <= data0;
            msg.velocity <= midi_byte[6:0];
            // Note-on with zero velocity acts as note-off
            if (run_kind == synth_pkg::note_on && midi_byte[6:0] == '0) begin
                msg.kind <= synth_pkg::note_off;
            end else begin
                msg.kind <= run_kind;
            end
        end
    end

endmodule

// ==== logic/midi_synth_top.sv ====
// MIDI square-wave synth top

module midi_synth_top (
    input  logic                      reset,
    input  logic                      clk,
    input  logic [7:0]                midi_byte,
    input  logic                      midi_byte_valid,
    input  logic [3:0]                channel,
    output logic                      sample_valid,
    output synth_pkg::stereo_sample_t sample
);

    logic                   msg_valid;
    synth_pkg::midi_msg_t   msg;
    logic                   ev_valid;
    synth_pkg::note_event_t ev;
    logic                   sample_tick;

    midi_msg_parser parser_i (
        .reset           (reset),
        .clk             (clk),
        .midi_byte       (midi_byte),
        .midi_byte_valid (midi_byte_valid),
        .channel         (channel),
        .msg_valid       (msg_valid),
        .msg             (msg)
    );

    pitch_lookup pitch_i (
        .reset     (reset),
        .clk       (clk),
        .msg_valid (msg_valid),
        .msg       (msg),
        .ev_valid  (ev_valid),
        .ev        (ev)
    );

    sample_rate_gen rate_i (
        .reset       (reset),
        .clk         (clk),
        .sample_tick (sample_tick)
    );

    pulse_voice voice_i (
        .reset        (reset),
        .clk          (clk),
        .ev_valid     (ev_valid),
        .ev           (ev),
        .sample_tick  (sample_tick),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

endmodule

// ==== logic/pitch_lookup.sv ====
// Note to half-period divider

`include "synth_settings.svh"

module pitch_lookup (
    input  logic                   reset,
    input  logic                   clk,
    input  logic                   msg_valid,
    input  synth_pkg::midi_msg_t   msg,
    output logic                   ev_valid,
    output synth_pkg::note_event_t ev
);

    logic [3:0]               octave;
    logic [3:0]               step;
    logic [`SYNTH_DIV_W-1:0]  divider;

    // Divide by constant, note is only 7 bits
    assign octave  = 4'(msg.note / `SYNTH_NOTE_W'(`SYNTH_STEPS));
    assign step    = 4'(msg.note % `SYNTH_NOTE_W'(`SYNTH_STEPS));
    assign divider = synth_pkg::pitch_base[step] >> octave;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= msg_valid;
        end
    end

    always_ff @(posedge reset) begin
        if (msg_valid) begin
            ev.kind        <= msg.kind;
            ev.velocity    <= msg.velocity;
            ev.half_period <= divider;
        end
    end

endmodule

// ==== logic/pulse_voice.sv ====
// Square-wave voice with stereo sample output

`include "synth_settings.svh"

module pulse_voice (
    input  logic                      reset,
    input  logic                      clk,
    input  logic                      ev_valid,
    input  synth_pkg::note_event_t    ev,
    input  logic                      sample_tick,
    output logic                      sample_valid,
    output synth_pkg::stereo_sample_t sample
);

    logic [`SYNTH_DIV_W-1:0]           half_period;
    logic [`SYNTH_DIV_W-1:0]           div_cnt;
    logic signed [`SYNTH_SAMPLE_W-1:0] level;
    logic signed [`SYNTH_SAMPLE_W-1:0] on_level;
    logic                              half_done;

    // Velocity scaled into Q2.16, always positive
    assign on_level  = signed'(`SYNTH_SAMPLE_W'({ev.velocity, 9'b0}));
    assign half_done = div_cnt == half_period;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            half_period <= '0;
            div_cnt     <= '0;
            level       <= '0;
        end else if (ev_valid && ev.kind == synth_pkg::note_on) begin
            // Restart phase even while a note sounds
            half_period <= ev.half_period;
            div_cnt     <= '0;
            level       <= on_level;
        end else if (ev_valid && ev.kind == synth_pkg::note_off) begin
            div_cnt <= '0;
            level   <= '0;
        end else if (half_done) begin
            div_cnt <= '0;
            level   <= -level;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Both channels carry the same level
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sample_valid <= 1'b0;
            sample       <= '0;
        end else if (sample_tick) begin
            sample_valid <= 1'b1;
            sample.left  <= level;
            sample.right <= level;
        end else begin
            sample_valid <= 1'b0;
            sample       <= '0;
        end
    end

endmodule

// ==== logic/sample_rate_gen.sv ====
// Sample rate strobe

`include "synth_settings.svh"

module sample_rate_gen (
    input  logic reset,
    input  logic clk,
    output logic sample_tick
);

    localparam int CNT_W = $clog2(`SYNTH_SAMPLE_DIV);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            cnt         <= '0;
            sample_tick <= 1'b0;
        end else if (cnt == CNT_W'(`SYNTH_SAMPLE_DIV - 1)) begin
            cnt         <= '0;
            sample_tick <= 1'b1;
        end else begin
            cnt         <= cnt + 1'b1;
            sample_tick <= 1'b0;
        end
    end

endmodule

// ==== logic/synth_pkg.sv ====
// Synth shared types

`include "synth_settings.svh"

package synth_pkg;

    typedef enum logic [1:0] {
        none     = 2'd0,
        note_on  = 2'd1,
        note_off = 2'd2
    } msg_kind_e;

    typedef struct packed {
        msg_kind_e                kind;
        logic [`SYNTH_NOTE_W-1:0] note;
        logic [`SYNTH_NOTE_W-1:0] velocity;
    } midi_msg_t;

    typedef struct packed {
        msg_kind_e                kind;
        logic [`SYNTH_NOTE_W-1:0] velocity;
        logic [`SYNTH_DIV_W-1:0]  half_period;
    } note_event_t;

    typedef struct packed {
        logic signed [`SYNTH_SAMPLE_W-1:0] left;
        logic signed [`SYNTH_SAMPLE_W-1:0] right;
    } stereo_sample_t;

    // Half-period counts for notes 0 to 11, higher octaves shift right
    localparam logic [`SYNTH_DIV_W-1:0] pitch_base [`SYNTH_STEPS] = '{
        32'h005d_5084,
        32'h0058_13c2,
        32'h0053_2240,
        32'h004e_77c5,
        32'h004a_1054,
        32'h0045_e82b,
        32'h0041_fbbc,
        32'h003e_47ac,
        32'h003a_c8d3,
        32'h0037_7c32,
        32'h0034_5efa,
        32'h0031_6e80
    };

endpackage

// ==== logic/synth_settings.svh ====
// Synth build constants

`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// Signed audio sample, Q2.16
`define SYNTH_SAMPLE_W 18

// Half-period divider
`define SYNTH_DIV_W 32

// Clock cycles per output sample
`define SYNTH_SAMPLE_DIV 256

// Note number and data byte payload
`define SYNTH_NOTE_W 7

// Semitones per octave, size of the pitch base table
`define SYNTH_STEPS 12

`endif

// ==== sim/tb_midi_synth_tests.svh ====
// Directed tests for the MIDI synth

// Starts on a falling edge and returns on the next one
task automatic send_byte(input logic [7:0] b);
    midi_byte       = b;
    midi_byte_valid = 1'b1;
    @(negedge reset);
    midi_byte_valid = 1'b0;
    midi_byte       = 8'h00;
endtask

task automatic send_note(input logic [3:0] kind_nib, input logic [6:0] note,
                         input logic [6:0] vel);
    send_byte({kind_nib, listen_chan});
    send_byte({1'b0, note});
    send_byte({1'b0, vel});
endtask

task automatic wait_sample();
    int waited;
    waited = 0;
    do begin
        @(negedge reset);
        waited++;
        if (waited > 2 * `SYNTH_SAMPLE_DIV) begin
            $display("no sample_valid within two sample periods");
            report_failure();
        end
    end while (!sample_valid);
endtask

task automatic test_idle_zero();
    for (int i = 0; i < idle_samples; i++) begin
        wait_sample();
        check_sample(sample, '0, "idle");
    end
endtask

task automatic test_note_on_level();
    logic [6:0] vel;
    vel = 7'(1 + next_random() % 127);
    send_note(4'h9, 7'd60, vel);
    wait_sample();
    check_sample(sample, note_on_sample(vel), "first after note-on");
    wait_sample();
endtask

task automatic test_pitch_high();
    logic [6:0] note;
    logic [6:0] vel;
    for (int n = 0; n < pitch_notes; n++) begin
        note = 7'(96 + next_random() % 32);
        vel  = 7'(1 + next_random() % 127);
        send_note(4'h9, note, vel);
        repeat (pitch_samples) wait_sample();
    end
endtask

task automatic test_note_off();
    send_note(4'h9, 7'd64, 7'd100);
    repeat (off_samples) wait_sample();
    send_note(4'h8, 7'd64, 7'd40);
    wait_sample();
    check_sample(sample, '0, "after note-off");
    send_note(4'h9, 7'd64, 7'd100);
    repeat (off_samples) wait_sample();
    // Velocity zero on note-on
    send_note(4'h9, 7'd64, 7'd0);
    wait_sample();
    check_sample(sample, '0, "after zero velocity");
endtask

task automatic test_running_status();
    logic [6:0] vel;
    vel = 7'(1 + next_random() % 127);
    send_note(4'h9, 7'd100, 7'd90);
    repeat (run_samples) wait_sample();
    // Data bytes only retune
    send_byte(8'd110);
    send_byte({1'b0, vel});
    repeat (run_samples) wait_sample();
    send_byte({4'h9, listen_chan + 4'd1});
    send_byte(8'd50);
    send_byte(8'd90);
    repeat (run_samples) wait_sample();
    // Control change followed by stray data bytes
    send_byte({4'hb, listen_chan});
    send_byte(8'd7);
    send_byte(8'd100);
    send_byte(8'd40);
    send_byte(8'd64);
    repeat (run_samples) wait_sample();
    // Note 110 is still in its first half period here
    check_sample(sample, note_on_sample(vel), "level after ignored messages");
endtask

task automatic test_retrigger();
    logic [6:0] vel;
    int         waited;
    send_note(4'h9, 7'd120, 7'd80);
    waited = 0;
    do begin
        wait_sample();
        waited++;
        if (waited > retrig_limit) begin
            $display("no negative half period seen before retrigger");
            report_failure();
        end
    end while (sample.left >= 0);
    vel = 7'(1 + next_random() % 127);
    send_note(4'h9, 7'd121, vel);
    wait_sample();
    check_sample(sample, note_on_sample(vel), "after retrigger");
endtask

// ==== sim/tb_midi_synth.sv ====
// MIDI synth testbench

`include "synth_settings.svh"

module tb_midi_synth;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] listen_chan = 4'h3;
    localparam int idle_samples  = 8;
    localparam int pitch_notes   = 3;
    localparam int pitch_samples = 192;
    localparam int off_samples   = 3;
    localparam int run_samples   = 6;
    localparam int retrig_limit  = 40;
    localparam int total_samples = idle_samples + 2 + pitch_notes * pitch_samples
                                 + 2 * off_samples + 2 + 4 * run_samples + retrig_limit + 1;

    // Port reset carries the clock and port clk carries the reset
    logic                      reset;
    logic                      clk;
    logic [7:0]                midi_byte;
    logic                      midi_byte_valid;
    logic [3:0]                channel;
    logic                      sample_valid;
    synth_pkg::stereo_sample_t sample;

    logic [31:0] rng_state = 32'h1c71_c9d5;

    // Reference model state counted in edges since reset release
    longint                            cycle_n = 0;
    longint                            next_valid = `SYNTH_SAMPLE_DIV + 1;
    synth_pkg::msg_kind_e              m_kind = synth_pkg::none;
    logic [3:0]                        m_chan = 4'd0;
    logic                              m_have_first = 1'b0;
    logic [`SYNTH_NOTE_W-1:0]          m_first = '0;
    longint                            pend_edge [$];
    synth_pkg::note_event_t            pend_ev [$];
    logic                              m_sounding = 1'b0;
    int                                m_mag = 0;
    longint                            m_start = 0;
    longint                            m_half = 0;
    logic signed [`SYNTH_SAMPLE_W-1:0] m_level = '0;
    logic signed [`SYNTH_SAMPLE_W-1:0] m_tick_level = '0;

    midi_synth_top dut_i (
        .reset           (reset),
        .clk             (clk),
        .midi_byte       (midi_byte),
        .midi_byte_valid (midi_byte_valid),
        .channel         (channel),
        .sample_valid    (sample_valid),
        .sample          (sample)
    );

    initial begin
        reset = 1'b0;
        forever #5 reset = ~reset;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic synth_pkg::stereo_sample_t note_on_sample(input logic [6:0] vel);
        synth_pkg::stereo_sample_t s;
        s.left  = `SYNTH_SAMPLE_W'(int'(vel) * 512);
        s.right = `SYNTH_SAMPLE_W'(int'(vel) * 512);
        return s;
    endfunction

    task automatic report_failure();
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_sample(input synth_pkg::stereo_sample_t actual,
                                input synth_pkg::stereo_sample_t expected,
                                input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s sample left %0d right %0d, expected left %0d right %0d",
                     $time, what, actual.left, actual.right, expected.left, expected.right);
            report_failure();
        end
    endtask

    task automatic check_tick(input longint actual, input longint expected);
        if (actual != expected) begin
            $display("MISMATCH at %0t: sample_valid in cycle %0d, expected cycle %0d",
                     $time, actual, expected);
            report_failure();
        end
    endtask

    // Event reaches the voice two edges after the last byte
    task automatic model_parser();
        synth_pkg::note_event_t ev;
        if (midi_byte_valid && midi_byte[7]) begin
            m_have_first = 1'b0;
            m_chan       = midi_byte[3:0];
            if (midi_byte[7:4] == 4'h9) begin
                m_kind = synth_pkg::note_on;
            end else if (midi_byte[7:4] == 4'h8) begin
                m_kind = synth_pkg::note_off;
            end else begin
                m_kind = synth_pkg::none;
            end
        end else if (midi_byte_valid && m_kind != synth_pkg::none) begin
            if (!m_have_first) begin
                m_first      = midi_byte[6:0];
                m_have_first = 1'b1;
            end else begin
                m_have_first = 1'b0;
                if (m_chan == channel) begin
                    if (m_kind == synth_pkg::note_on && midi_byte[6:0] == 7'd0) begin
                        ev.kind = synth_pkg::note_off;
                    end else begin
                        ev.kind = m_kind;
                    end
                    ev.velocity    = midi_byte[6:0];
                    ev.half_period = synth_pkg::pitch_base[m_first % 12] >> (m_first / 12);
                    pend_edge.push_back(cycle_n + 2);
                    pend_ev.push_back(ev);
                end
            end
        end
    endtask

    // Level from the phase since the last note-on
    task automatic model_voice();
        synth_pkg::note_event_t ev;
        longint                 phase;
        while (pend_edge.size() > 0 && pend_edge[0] == cycle_n) begin
            void'(pend_edge.pop_front());
            ev = pend_ev.pop_front();
            if (ev.kind == synth_pkg::note_on) begin
                m_sounding = 1'b1;
                m_mag      = int'(ev.velocity) * 512;
                m_start    = cycle_n;
                m_half     = longint'(ev.half_period);
            end else begin
                m_sounding = 1'b0;
            end
        end
        if (!m_sounding) begin
            m_level = '0;
        end else begin
            phase = (cycle_n - m_start) / (m_half + 1);
            m_level = (phase % 2 == 0) ? `SYNTH_SAMPLE_W'(m_mag) : `SYNTH_SAMPLE_W'(-m_mag);
        end
    endtask

    always @(posedge reset) begin
        if (!clk) begin
            cycle_n = cycle_n + 1;
            model_parser();
            model_voice();
            if (cycle_n % `SYNTH_SAMPLE_DIV == 0) begin
                m_tick_level = m_level;
            end
        end
    end

    always @(negedge reset) begin : sample_monitor
        synth_pkg::stereo_sample_t expected;
        if (!clk && cycle_n > 0) begin
            expected = '0;
            if (sample_valid) begin
                check_tick(cycle_n, next_valid);
                next_valid     = next_valid + `SYNTH_SAMPLE_DIV;
                expected.left  = m_tick_level;
                expected.right = m_tick_level;
            end else if (cycle_n >= next_valid) begin
                $display("sample_valid did not arrive in cycle %0d", next_valid);
                report_failure();
            end
            check_sample(sample, expected, "model");
        end
    end

    initial begin : watchdog
        repeat ((total_samples + 16) * `SYNTH_SAMPLE_DIV + 10) @(posedge reset);
        $display("timeout: the tests did not finish in time");
        report_failure();
    end

    `include "tb_midi_synth_tests.svh"

    initial begin
        midi_byte       = 8'h00;
        midi_byte_valid = 1'b0;
        channel         = listen_chan;
        clk             = 1'b1;
        repeat (10) @(negedge reset);
        clk = 1'b0;
        test_idle_zero();
        test_note_on_level();
        test_pitch_high();
        test_note_off();
        test_running_status();
        test_retrigger();
        $display("all tests passed");
        $finish;
    end

endmodule
